//--- filelist.f
mbox_pkg.sv
cdc_ptr_sync.sv
cdc_fifo_src.sv
cdc_fifo_dst.sv
cdc_fifo_gray.sv
mbox_ctrl.sv
mbox_top.sv
tb_clk_gen.sv
tb_mbox.sv

//--- run.sh
#!/bin/sh
# build and run the mailbox testbench, a non-zero exit means the regression failed
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_mbox -f filelist.f -o sim_mbox \
  > build.log 2>&1 &&
./obj_dir/sim_mbox > sim.log 2>&1 || { echo "build or simulation did not complete"; exit 1; }
grep -q "Regression failed" sim.log && { tail -n 5 sim.log; exit 1; } || { tail -n 2 sim.log; exit 0; }

//--- tb_mbox.sv
// checks the mailbox from the AXI4-Lite host to the stream sink against a queue model
// LOG_DEPTH and SYNC_STAGES here must be the values handed to the DUT
module tb_mbox;

  import mbox_pkg::*;

  localparam int          LOG_DEPTH   = 3;
  localparam int          SYNC_STAGES = 2;
  localparam int          DEPTH       = 2**LOG_DEPTH;
  localparam int          LIMIT       = 2000;
  localparam logic [31:0] SEED        = 32'h75c8_5129;

  logic        src_clk;
  logic        dst_clk;
  logic        rst_n;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  mbox_msg_t   dst_msg;
  logic        dst_valid;
  logic        dst_ready;

  // model state: messages still owed to the stream, pushes so far and the tag register
  mbox_msg_t   exp_q[$];
  int unsigned push_count;
  logic [7:0]  model_tag;
  int          errors;
  int          checks;
  string       test_name;
  // sink behaviour, 0 random ready, 1 ready held low, 2 ready held high
  int          ready_mode;
  logic [1:0]  resp;
  logic [31:0] rdata;
  int          polls;

  tb_clk_gen #(.PERIOD(10), .OFFSET(0)) src_clk_gen_i (.clk_o(src_clk));
  tb_clk_gen #(.PERIOD(10), .OFFSET(3)) dst_clk_gen_i (.clk_o(dst_clk));

  mbox_top #(
    .LOG_DEPTH   (LOG_DEPTH),
    .SYNC_STAGES (SYNC_STAGES)
  ) mbox_top_i (
    .src_clk_i   (src_clk),
    .dst_clk_i   (dst_clk),
    .rst_n_i     (rst_n),
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp),
    .dst_msg_o   (dst_msg),
    .dst_valid_o (dst_valid),
    .dst_ready_i (dst_ready)
  );

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    errors++;
    $display("ERROR %s %s: expected %0h actual %0h", test_name, what, exp, act);
  endtask

  task automatic end_run();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    errors++;
    $display("%s: timed out while %s", test_name, what);
    end_run();
  endtask

  // one full write, the model is updated up front since the DUT never drops a write
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] bresp);
    int   cycles;
    logic taken;
    cycles = 0;
    if (addr == REG_DATA) begin
      exp_q.push_back('{tag: model_tag, data: data});
      push_count++;
    end else if (addr == REG_TAG) begin
      model_tag = data[7:0];
    end
    @(negedge src_clk);
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    // strobes are ignored by the slave, so any pattern must behave the same
    axil_req.w_strb   = 4'($urandom);
    // the ready pair is looked at just before the edge that may take the write
    do begin
      @(posedge src_clk);
      taken = axil_rsp.aw_ready;
      if (axil_rsp.w_ready !== taken) begin
        errors++;
        $display("%s: awready and wready were not raised together", test_name);
      end
      @(negedge src_clk);
      cycles++;
      if (cycles > LIMIT) begin
        fail_timeout("waiting for the write to be accepted");
      end
    end while (taken !== 1'b1);
    // bvalid comes from the edge that took aw and w, and the ready pulse is already over
    checks++;
    if (axil_rsp.b_valid !== 1'b1 || axil_rsp.aw_ready !== 1'b0) begin
      errors++;
      $display("%s: bvalid did not follow the accepted write", test_name);
    end
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    bresp = axil_rsp.b_resp;
    repeat ($urandom_range(0, 2)) begin
      @(negedge src_clk);
      if (!axil_rsp.b_valid) begin
        errors++;
        $display("%s: bvalid dropped before bready was given", test_name);
      end
    end
    axil_req.b_ready = 1'b1;
    @(negedge src_clk);
    axil_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] rresp);
    int cycles;
    cycles = 0;
    @(negedge src_clk);
    // no read is pending here, so the address channel has to be open
    checks++;
    if (axil_rsp.ar_ready !== 1'b1) begin
      errors++;
      $display("%s: arready was low with no read pending", test_name);
    end
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    do begin
      @(negedge src_clk);
      cycles++;
      if (cycles > LIMIT) begin
        fail_timeout("waiting for the read response");
      end
    end while (!axil_rsp.r_valid);
    axil_req.ar_valid = 1'b0;
    // rvalid follows the edge that took the address
    checks++;
    if (cycles != 1) begin
      errors++;
      $display("%s: rvalid came %0d cycles after arvalid instead of 1", test_name, cycles);
    end
    data  = axil_rsp.r_data;
    rresp = axil_rsp.r_resp;
    axil_req.r_ready = 1'b1;
    @(negedge src_clk);
    axil_req.r_ready = 1'b0;
  endtask

  // the sink records a pop at the falling edge before the rising edge that takes it
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(negedge src_clk);
      cycles++;
      if (cycles > LIMIT) begin
        fail_timeout("draining the stream");
      end
    end
  endtask

  // stream sink, chooses ready at each falling edge and checks what it is about to take
  initial begin : stream_sink
    mbox_msg_t exp_msg;
    dst_ready = 1'b0;
    forever begin
      @(negedge dst_clk);
      case (ready_mode)
        0:       dst_ready = 1'($urandom);
        1:       dst_ready = 1'b0;
        default: dst_ready = 1'b1;
      endcase
      if (rst_n && dst_valid && dst_ready) begin
        checks++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: message %0h came out with nothing left to pop", test_name, dst_msg);
        end else begin
          exp_msg = exp_q.pop_front();
          if (dst_msg !== exp_msg) begin
            report_mismatch("stream message", 64'(exp_msg), 64'(dst_msg));
          end
        end
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    rst_n      = 1'b0;
    axil_req   = '0;
    ready_mode = 2;
    push_count = 0;
    model_tag  = '0;
    errors     = 0;
    checks     = 0;
    test_name  = "reset";
    // both clocks run while reset is held and released
    repeat (3) @(negedge src_clk);
    rst_n = 1'b1;

    checks++;
    if (axil_rsp.b_valid || axil_rsp.r_valid || dst_valid) begin
      report_mismatch("valids", 64'd0, {axil_rsp.b_valid, axil_rsp.r_valid, dst_valid});
    end
    axil_read(REG_STATUS, rdata, resp);
    checks++;
    if (rdata !== 32'd1 || resp !== RESP_OKAY) begin
      report_mismatch("status", 64'd1, {resp, rdata});
    end
    axil_read(REG_TAG, rdata, resp);
    checks++;
    if (rdata !== 32'd0 || resp !== RESP_OKAY) begin
      report_mismatch("tag", 64'd0, {resp, rdata});
    end

    // mixed tag and data writes while the sink stalls at random
    test_name  = "random";
    ready_mode = 0;
    for (int i = 0; i < 200; i++) begin
      if ($urandom_range(0, 3) == 0) begin
        axil_write(REG_TAG, $urandom, resp);
      end else begin
        axil_write(REG_DATA, $urandom, resp);
      end
      checks++;
      if (resp !== RESP_OKAY) begin
        report_mismatch("write response", 64'(RESP_OKAY), 64'(resp));
      end
    end
    ready_mode = 2;
    wait_drained();

    // with the sink stalled, depth plus the two spill slots fill everything up
    test_name  = "full";
    ready_mode = 1;
    for (int i = 0; i < DEPTH + 2; i++) begin
      axil_write(REG_DATA, $urandom, resp);
    end
    polls = 0;
    do begin
      axil_read(REG_STATUS, rdata, resp);
      polls++;
      if (polls > 50) begin
        fail_timeout("polling for the FIFO to report full");
      end
    end while (rdata[0]);
    checks++;
    if (rdata[31:1] !== 31'(push_count)) begin
      report_mismatch("push count", 64'(push_count), 64'(rdata[31:1]));
    end
    ready_mode = 2;
    wait_drained();

    // bad writes must not touch the count or the tag, bad reads return zero
    test_name = "errors";
    axil_write(REG_STATUS, $urandom, resp);
    checks++;
    if (resp !== RESP_SLVERR) begin
      report_mismatch("status write", 64'(RESP_SLVERR), 64'(resp));
    end
    axil_write(4'hc, $urandom, resp);
    checks++;
    if (resp !== RESP_SLVERR) begin
      report_mismatch("unmapped write", 64'(RESP_SLVERR), 64'(resp));
    end
    axil_read(REG_DATA, rdata, resp);
    checks++;
    if (resp !== RESP_SLVERR || rdata !== 32'd0) begin
      report_mismatch("data read", {RESP_SLVERR, 32'd0}, {resp, rdata});
    end
    axil_read(4'hc, rdata, resp);
    checks++;
    if (resp !== RESP_SLVERR || rdata !== 32'd0) begin
      report_mismatch("unmapped read", {RESP_SLVERR, 32'd0}, {resp, rdata});
    end

    // final state once everything has left through the stream
    test_name = "final";
    wait_drained();
    axil_read(REG_STATUS, rdata, resp);
    checks++;
    if (rdata[31:1] !== 31'(push_count) || resp !== RESP_OKAY) begin
      report_mismatch("push count", 64'(push_count), 64'(rdata[31:1]));
    end
    axil_read(REG_TAG, rdata, resp);
    checks++;
    if (rdata !== {24'd0, model_tag} || resp !== RESP_OKAY) begin
      report_mismatch("tag", 64'(model_tag), 64'(rdata));
    end
    end_run();
  end

endmodule

//--- tb_clk_gen.sv
// free-running testbench clock, the first rising edge comes OFFSET plus half a period in
module tb_clk_gen #(
  parameter int PERIOD = 10,
  parameter int OFFSET = 0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    // shift this clock against the others so the edges never line up
    #(OFFSET);
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;
    end
  end

endmodule

//--- mbox_top.sv
// host-to-stream mailbox with one reset applied asynchronously to both clocks
// release reset only while both clocks run, there is no reset synchronizer
module mbox_top #(
  parameter int LOG_DEPTH   = 3,
  parameter int SYNC_STAGES = 2
) (
  input  logic                src_clk_i,
  input  logic                dst_clk_i,
  input  logic                rst_n_i,
  input  mbox_pkg::axil_req_t axil_req_i,
  output mbox_pkg::axil_rsp_t axil_rsp_o,
  output mbox_pkg::mbox_msg_t dst_msg_o,
  output logic                dst_valid_o,
  input  logic                dst_ready_i
);

  import mbox_pkg::*;

  // push handshake lives entirely in the source clock
  mbox_msg_t push_msg;
  logic      push_valid;
  logic      push_ready;

  mbox_ctrl ctrl_i (
    .src_clk_i    (src_clk_i),
    .rst_n_i      (rst_n_i),
    .axil_req_i   (axil_req_i),
    .axil_rsp_o   (axil_rsp_o),
    .push_msg_o   (push_msg),
    .push_valid_o (push_valid),
    .push_ready_i (push_ready)
  );

  cdc_fifo_gray #(
    .LOG_DEPTH    (LOG_DEPTH),
    .SYNC_STAGES  (SYNC_STAGES)
  ) fifo_i (
    .src_clk_i    (src_clk_i),
    .dst_clk_i    (dst_clk_i),
    .rst_n_i      (rst_n_i),
    .push_msg_i   (push_msg),
    .push_valid_i (push_valid),
    .push_ready_o (push_ready),
    .dst_msg_o    (dst_msg_o),
    .dst_valid_o  (dst_valid_o),
    .dst_ready_i  (dst_ready_i)
  );

endmodule

//--- mbox_ctrl.sv
// AXI4-Lite slave of the mailbox, one outstanding write and one outstanding read
// write strobes are ignored and every write is taken as a full word
module mbox_ctrl (
  input  logic                src_clk_i,
  input  logic                rst_n_i,
  input  mbox_pkg::axil_req_t axil_req_i,
  output mbox_pkg::axil_rsp_t axil_rsp_o,
  output mbox_pkg::mbox_msg_t push_msg_o,
  output logic                push_valid_o,
  input  logic                push_ready_i
);

  import mbox_pkg::*;

  logic        wr_req;
  logic        wr_is_data;
  logic        wr_is_tag;
  logic        wr_accept;
  logic [1:0]  wr_resp;
  logic        rd_accept;
  logic [31:0] rd_data;
  logic [1:0]  rd_resp;
  logic        b_valid_q;
  logic [1:0]  b_resp_q;
  logic        r_valid_q;
  logic [31:0] r_data_q;
  logic [1:0]  r_resp_q;
  logic [7:0]  tag_q;
  logic [30:0] push_cnt_q;

  // address and data are taken together once the previous response is gone
  assign wr_req     = axil_req_i.aw_valid & axil_req_i.w_valid & !b_valid_q;
  assign wr_is_data = (axil_req_i.aw_addr == REG_DATA);
  assign wr_is_tag  = (axil_req_i.aw_addr == REG_TAG);
  // a data write waits for FIFO space, which stalls the host instead of dropping
  assign wr_accept  = wr_req & (!wr_is_data | push_ready_i);
  assign wr_resp    = (wr_is_data | wr_is_tag) ? RESP_OKAY : RESP_SLVERR;

  // the pushed message carries the tag as it stands when the data arrives
  assign push_valid_o = wr_req & wr_is_data;
  assign push_msg_o   = '{tag: tag_q, data: axil_req_i.w_data};

  assign rd_accept = axil_req_i.ar_valid & !r_valid_q;

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (axil_req_i.ar_addr)
      REG_TAG: begin
        rd_data = {24'd0, tag_q};
      end
      REG_STATUS: begin
        // bit 0 tells the host whether a data write would go through now
        rd_data = {push_cnt_q, push_ready_i};
      end
      default: begin
        // the data register is write only, so it falls in here too
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge src_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q  <= 1'b0;
      r_valid_q  <= 1'b0;
      tag_q      <= '0;
      push_cnt_q <= '0;
    end else begin
      if (wr_accept) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_accept) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
      if (wr_accept && wr_is_data) begin
        push_cnt_q <= push_cnt_q + 1'b1;
      end
      if (wr_accept && wr_is_tag) begin
        tag_q <= axil_req_i.w_data[7:0];
      end
    end
  end

  // response payloads only matter while their valid is high
  always_ff @(posedge src_clk_i) begin
    if (wr_accept) begin
      b_resp_q <= wr_resp;
    end
    if (rd_accept) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp_o          = '0;
    axil_rsp_o.aw_ready = wr_accept;
    axil_rsp_o.w_ready  = wr_accept;
    axil_rsp_o.b_valid  = b_valid_q;
    axil_rsp_o.b_resp   = b_resp_q;
    axil_rsp_o.ar_ready = !r_valid_q;
    axil_rsp_o.r_valid  = r_valid_q;
    axil_rsp_o.r_data   = r_data_q;
    axil_rsp_o.r_resp   = r_resp_q;
  end

  // a write response is held with its code until the host takes it
  a_bvalid_held: assert property (
    @(posedge src_clk_i) disable iff (!rst_n_i)
    axil_rsp_o.b_valid && !axil_req_i.b_ready
      |=> axil_rsp_o.b_valid && $stable(axil_rsp_o.b_resp)
  );

endmodule

//--- cdc_fifo_gray.sv
// gray-pointer CDC FIFO for mailbox messages, depth 2**LOG_DEPTH plus two output slots
// the async_* nets need max-delay and false-path constraints in implementation
module cdc_fifo_gray #(
  parameter int LOG_DEPTH   = 3,
  parameter int SYNC_STAGES = 2
) (
  input  logic                src_clk_i,
  input  logic                dst_clk_i,
  input  logic                rst_n_i,
  input  mbox_pkg::mbox_msg_t push_msg_i,
  input  logic                push_valid_i,
  output logic                push_ready_o,
  output mbox_pkg::mbox_msg_t dst_msg_o,
  output logic                dst_valid_o,
  input  logic                dst_ready_i
);

  import mbox_pkg::*;

  // these nets cross between the two clocks
  mbox_msg_t [2**LOG_DEPTH-1:0] async_data;
  logic [LOG_DEPTH:0]           async_wptr;
  logic [LOG_DEPTH:0]           async_rptr;

  cdc_fifo_src #(
    .LOG_DEPTH    (LOG_DEPTH),
    .SYNC_STAGES  (SYNC_STAGES)
  ) src_i (
    .src_clk_i    (src_clk_i),
    .rst_n_i      (rst_n_i),
    .push_msg_i   (push_msg_i),
    .push_valid_i (push_valid_i),
    .push_ready_o (push_ready_o),
    .async_data_o (async_data),
    .async_wptr_o (async_wptr),
    .async_rptr_i (async_rptr)
  );

  cdc_fifo_dst #(
    .LOG_DEPTH    (LOG_DEPTH),
    .SYNC_STAGES  (SYNC_STAGES)
  ) dst_i (
    .dst_clk_i    (dst_clk_i),
    .rst_n_i      (rst_n_i),
    .dst_msg_o    (dst_msg_o),
    .dst_valid_o  (dst_valid_o),
    .dst_ready_i  (dst_ready_i),
    .async_data_i (async_data),
    .async_wptr_i (async_wptr),
    .async_rptr_o (async_rptr)
  );

endmodule

//--- cdc_fifo_dst.sv
// read side of the gray-pointer CDC FIFO with a two-slot spill register on the output
// stream outputs come from flops, so dst_ready_i has no combinational path into the FIFO
module cdc_fifo_dst #(
  parameter int LOG_DEPTH   = 3,
  parameter int SYNC_STAGES = 2
) (
  input  logic                                   dst_clk_i,
  input  logic                                   rst_n_i,
  output mbox_pkg::mbox_msg_t                    dst_msg_o,
  output logic                                   dst_valid_o,
  input  logic                                   dst_ready_i,
  input  mbox_pkg::mbox_msg_t [2**LOG_DEPTH-1:0] async_data_i,
  input  logic [LOG_DEPTH:0]                     async_wptr_i,
  output logic [LOG_DEPTH:0]                     async_rptr_o
);

  import mbox_pkg::*;

  localparam int PTR_WIDTH = LOG_DEPTH + 1;

  logic [PTR_WIDTH-1:0] rptr_q;
  logic [PTR_WIDTH-1:0] rptr_bin;
  logic [PTR_WIDTH-1:0] rptr_next_bin;
  logic [PTR_WIDTH-1:0] rptr_next_gray;
  logic [PTR_WIDTH-1:0] wptr_gray;
  logic [PTR_WIDTH-1:0] wptr_bin;
  mbox_msg_t            fifo_msg;
  logic                 fifo_valid;
  logic                 spill_ready;
  logic                 pop;
  mbox_msg_t            a_msg_q;
  mbox_msg_t            b_msg_q;
  logic                 a_full_q;
  logic                 b_full_q;
  logic                 a_fill;
  logic                 a_drain;
  logic                 b_fill;
  logic                 b_drain;

  // the write pointer lags, so any slot it covers was written long enough ago
  cdc_ptr_sync #(
    .WIDTH       (PTR_WIDTH),
    .SYNC_STAGES (SYNC_STAGES)
  ) wptr_sync_i (
    .clk_i       (dst_clk_i),
    .rst_n_i     (rst_n_i),
    .ptr_async_i (async_wptr_i),
    .ptr_sync_o  (wptr_gray)
  );

  assign wptr_bin       = PTR_WIDTH'(gray_to_bin(8'(wptr_gray)));
  assign rptr_bin       = PTR_WIDTH'(gray_to_bin(8'(rptr_q)));
  assign rptr_next_bin  = rptr_bin + 1'b1;
  assign rptr_next_gray = PTR_WIDTH'(bin_to_gray(8'(rptr_next_bin)));

  // equal pointers including the wrap bit mean nothing is stored
  assign fifo_valid = (wptr_bin != rptr_bin);
  assign fifo_msg   = async_data_i[rptr_bin[LOG_DEPTH-1:0]];
  assign pop        = fifo_valid & spill_ready;

  always_ff @(posedge dst_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rptr_q <= '0;
    end else if (pop) begin
      rptr_q <= rptr_next_gray;
    end
  end

  assign async_rptr_o = rptr_q;

  // slot a takes new entries, slot b holds the older one when the sink stalls
  assign spill_ready = !a_full_q | !b_full_q;
  assign a_fill      = pop;
  assign a_drain     = a_full_q & !b_full_q;
  assign b_fill      = a_drain & !dst_ready_i;
  assign b_drain     = b_full_q & dst_ready_i;

  always_ff @(posedge dst_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge dst_clk_i) begin
    if (a_fill) begin
      a_msg_q <= fifo_msg;
    end
    if (b_fill) begin
      b_msg_q <= a_msg_q;
    end
  end

  // b is always older than a, so it goes out first
  assign dst_valid_o = a_full_q | b_full_q;
  assign dst_msg_o   = b_full_q ? b_msg_q : a_msg_q;

  // a stalled message must stay offered and unchanged
  a_stream_stable: assert property (
    @(posedge dst_clk_i) disable iff (!rst_n_i)
    dst_valid_o && !dst_ready_i |=> dst_valid_o && $stable(dst_msg_o)
  );

endmodule

//--- cdc_fifo_src.sv
// write side of the gray-pointer CDC FIFO, depth is 2**LOG_DEPTH with LOG_DEPTH from 1 to 7
// full is pessimistic because the read pointer arrives late through the synchronizer
module cdc_fifo_src #(
  parameter int LOG_DEPTH   = 3,
  parameter int SYNC_STAGES = 2
) (
  input  logic                                   src_clk_i,
  input  logic                                   rst_n_i,
  input  mbox_pkg::mbox_msg_t                    push_msg_i,
  input  logic                                   push_valid_i,
  output logic                                   push_ready_o,
  output mbox_pkg::mbox_msg_t [2**LOG_DEPTH-1:0] async_data_o,
  output logic [LOG_DEPTH:0]                     async_wptr_o,
  input  logic [LOG_DEPTH:0]                     async_rptr_i
);

  import mbox_pkg::*;

  // pointers carry one extra wrap bit above the slot index
  localparam int PTR_WIDTH = LOG_DEPTH + 1;
  localparam int DEPTH     = 2**LOG_DEPTH;
  // pointers that differ only in the wrap bit mean every slot is taken
  localparam logic [PTR_WIDTH-1:0] PTR_FULL = PTR_WIDTH'(DEPTH);

  mbox_msg_t [DEPTH-1:0] data_q;
  logic [PTR_WIDTH-1:0]  wptr_q;
  logic [PTR_WIDTH-1:0]  wptr_bin;
  logic [PTR_WIDTH-1:0]  wptr_next_bin;
  logic [PTR_WIDTH-1:0]  wptr_next_gray;
  logic [PTR_WIDTH-1:0]  rptr_gray;
  logic [PTR_WIDTH-1:0]  rptr_bin;
  logic                  push;

  assign push = push_valid_i & push_ready_o;

  // the write pointer is kept in gray form so it can be sent across as is
  assign wptr_bin       = PTR_WIDTH'(gray_to_bin(8'(wptr_q)));
  assign wptr_next_bin  = wptr_bin + 1'b1;
  assign wptr_next_gray = PTR_WIDTH'(bin_to_gray(8'(wptr_next_bin)));

  always_ff @(posedge src_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q <= '0;
    end else if (push) begin
      wptr_q <= wptr_next_gray;
    end
  end

  // storage, the slot is selected by the low bits of the binary write pointer
  always_ff @(posedge src_clk_i) begin
    if (push) begin
      data_q[wptr_bin[LOG_DEPTH-1:0]] <= push_msg_i;
    end
  end

  // bring the read pointer over from the destination clock
  cdc_ptr_sync #(
    .WIDTH       (PTR_WIDTH),
    .SYNC_STAGES (SYNC_STAGES)
  ) rptr_sync_i (
    .clk_i       (src_clk_i),
    .rst_n_i     (rst_n_i),
    .ptr_async_i (async_rptr_i),
    .ptr_sync_o  (rptr_gray)
  );

  assign rptr_bin = PTR_WIDTH'(gray_to_bin(8'(rptr_gray)));

  // a stale read pointer can only make the FIFO look fuller than it is
  assign push_ready_o = ((wptr_bin ^ rptr_bin) != PTR_FULL);

  assign async_data_o = data_q;
  assign async_wptr_o = wptr_q;

  // a push while full would lift the fill level seen here past the depth
  a_no_push_when_full: assert property (
    @(posedge src_clk_i) disable iff (!rst_n_i)
    PTR_WIDTH'(wptr_bin - rptr_bin) <= PTR_FULL
  );

endmodule

//--- cdc_ptr_sync.sv
// flop chain synchronizer, safe only for gray-coded inputs where one bit moves at a time
// SYNC_STAGES must be at least 2
module cdc_ptr_sync #(
  parameter int WIDTH       = 4,
  parameter int SYNC_STAGES = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [WIDTH-1:0] ptr_async_i,
  output logic [WIDTH-1:0] ptr_sync_o
);

  // stage 0 is the one that may go metastable
  logic [SYNC_STAGES-1:0][WIDTH-1:0] sync_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= ptr_async_i;
      // every later stage just shifts the previous one along
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // the last stage is settled and is handed to the receiving logic
  assign ptr_sync_o = sync_q[SYNC_STAGES-1];

endmodule

//--- mbox_pkg.sv
// shared types and helpers for the mailbox; the gray helpers cover pointers up to 8 bits,
// so FIFO users are limited to LOG_DEPTH of 7 or less
package mbox_pkg;

  // one mailbox message as it travels through the FIFO
  typedef struct packed {
    logic [7:0]  tag;
    logic [31:0] data;
  } mbox_msg_t;

  // AXI4-Lite channels driven by the host
  typedef struct packed {
    logic        aw_valid;
    logic [3:0]  aw_addr;
    logic        w_valid;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        b_ready;
    logic        ar_valid;
    logic [3:0]  ar_addr;
    logic        r_ready;
  } axil_req_t;

  // AXI4-Lite channels driven by the slave
  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    logic        b_valid;
    logic [1:0]  b_resp;
    logic        ar_ready;
    logic        r_valid;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
  } axil_rsp_t;

  // register byte offsets
  localparam logic [3:0] REG_DATA   = 4'h0;
  localparam logic [3:0] REG_TAG    = 4'h4;
  localparam logic [3:0] REG_STATUS = 4'h8;

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // callers zero-extend narrower pointers and truncate the result back
  function automatic logic [7:0] bin_to_gray(input logic [7:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the xor of all gray bits at or above it
  function automatic logic [7:0] gray_to_bin(input logic [7:0] gray);
    logic [7:0] bin;
    bin[7] = gray[7];
    for (int i = 6; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage
